// ==== logic/periph_pkg.sv ====
/*
 * APB bus widths and the peripheral address map.
 * The 12-bit address splits into a 4-bit window index and an 8-bit
 * register offset. Only windows 0 (GPIO) and 1 (timer) are mapped.
 */
package periph_pkg;

    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;
    localparam int unsigned REG_OFF_W  = 8;
    localparam int unsigned WIN_W      = APB_ADDR_W - REG_OFF_W;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [REG_OFF_W-1:0]  reg_off_t;

    // Window indices from the top address bits
    localparam logic [WIN_W-1:0] GPIO_BASE  = 4'h0;
    localparam logic [WIN_W-1:0] TIMER_BASE = 4'h1;

    // GPIO registers
    localparam reg_off_t GPIO_DIR        = 8'h00;
    localparam reg_off_t GPIO_OUT        = 8'h04;
    localparam reg_off_t GPIO_IN         = 8'h08;
    localparam reg_off_t GPIO_INT_EN     = 8'h0C;
    localparam reg_off_t GPIO_INT_STATUS = 8'h10;

    // Timer registers
    localparam reg_off_t TIM_CFG = 8'h00;
    localparam reg_off_t TIM_CNT = 8'h04;
    localparam reg_off_t TIM_CMP = 8'h08;

    // TIM_CFG fields
    localparam int unsigned TIM_CFG_EN  = 0;
    localparam int unsigned TIM_CFG_SRC = 1;

endpackage

// ==== logic/event_pkg.sv ====
/*
 * Fabric-controller event vector layout.
 * Only the timer, reference-clock and GPIO events are driven;
 * every other bit of the vector stays at zero.
 */
package event_pkg;

    localparam int unsigned FC_EVT_W = 32;

    typedef logic [FC_EVT_W-1:0] fc_event_t;

    ////////////////////
    // Bit positions
    ////////////////////

    // Compare timer wrap
    localparam int unsigned EVT_TIMER   = 10;

    // Either edge of the slow reference clock
    localparam int unsigned EVT_REF_CLK = 14;

    // Any newly detected enabled GPIO rising edge
    localparam int unsigned EVT_GPIO    = 15;

endpackage

// ==== logic/slow_clk_edge.sv ====
/*
 * Slow reference clock synchronizer and edge detector.
 * slow_clk_i must be much slower than clk_i; rise_o and fall_o
 * pulse for one cycle, 3 cycles after the level change.
 */
`timescale 1ns/10ps

module slow_clk_edge (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic slow_clk_i,
    output logic rise_o,
    output logic fall_o
);

    logic [1:0] sync_q;
    logic       dly_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
            dly_q  <= 1'b0;
            rise_o <= 1'b0;
            fall_o <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], slow_clk_i};
            dly_q  <= sync_q[1];
            // Registered edge pulses
            rise_o <= sync_q[1] & ~dly_q;
            fall_o <= ~sync_q[1] & dly_q;
        end
    end

    // Each slow clock level lasts at least two cycles
    edge_spacing_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rise_o || fall_o |=> !(rise_o || fall_o));

endmodule

// ==== logic/apb_periph_decode.sv ====
/*
 * APB window decoder for the peripheral subsystem.
 * Zero wait states: pready is high in every access cycle.
 * Unmapped windows answer with pslverr and zero read data.
 */
`timescale 1ns/10ps

module apb_periph_decode import periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // APB slave side
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    // Peripheral side
    output logic      gpio_sel_o,
    output logic      tim_sel_o,
    output logic      enable_o,
    output logic      write_o,
    output reg_off_t  offset_o,
    output apb_data_t wdata_o,
    input  apb_data_t gpio_rdata_i,
    input  apb_data_t tim_rdata_i
);

    logic [WIN_W-1:0] win;
    logic             access;

    assign win    = paddr_i[APB_ADDR_W-1 -: WIN_W];
    assign access = psel_i & penable_i;

    assign gpio_sel_o = psel_i & (win == GPIO_BASE);
    assign tim_sel_o  = psel_i & (win == TIMER_BASE);

    // Shared strobes qualified per peripheral by its select
    assign enable_o = penable_i;
    assign write_o  = pwrite_i;
    assign offset_o = paddr_i[REG_OFF_W-1:0];
    assign wdata_o  = pwdata_i;

    always_comb begin
        if (gpio_sel_o) begin
            prdata_o = gpio_rdata_i;
        end else if (tim_sel_o) begin
            prdata_o = tim_rdata_i;
        end else begin
            prdata_o = '0;
        end
    end

    assign pready_o  = access;
    assign pslverr_o = access & ~gpio_sel_o & ~tim_sel_o;

    // Address and direction hold from the setup into the access cycle
    addr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i && penable_i |-> $stable(paddr_i) && $stable(pwrite_i));

    // Access phase must follow a setup phase
    penable_after_psel_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(penable_i) |-> $past(psel_i));

endmodule

// ==== logic/apb_gpio.sv ====
/*
 * GPIO block with direction, output and interrupt-enable registers.
 * Inputs pass two synchronizer flops; an enabled rising edge sets a
 * sticky status bit and pulses gpio_evt_o, both 3 cycles after the pin.
 * Status is write-1-to-clear; a new edge wins over a clear. NGPIO <= 32.
 */
`timescale 1ns/10ps

module apb_gpio import periph_pkg::*; #(
    parameter int unsigned NGPIO = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             sel_i,
    input  logic             enable_i,
    input  logic             write_i,
    input  reg_off_t         offset_i,
    input  apb_data_t        wdata_i,
    output apb_data_t        rdata_o,
    input  logic [NGPIO-1:0] gpio_i,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,
    output logic             gpio_evt_o
);

    logic [NGPIO-1:0] dir_q, out_q, int_en_q, status_q;
    logic [NGPIO-1:0] sync1_q, sync2_q, prev_q;
    logic [NGPIO-1:0] edge_set;
    logic             wr;

    assign wr       = sel_i & enable_i & write_i;
    assign edge_set = sync2_q & ~prev_q & int_en_q;

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q      <= '0;
            out_q      <= '0;
            int_en_q   <= '0;
            status_q   <= '0;
            gpio_evt_o <= 1'b0;
        end else begin
            if (wr && offset_i == GPIO_DIR)    dir_q    <= wdata_i[NGPIO-1:0];
            if (wr && offset_i == GPIO_OUT)    out_q    <= wdata_i[NGPIO-1:0];
            if (wr && offset_i == GPIO_INT_EN) int_en_q <= wdata_i[NGPIO-1:0];
            if (wr && offset_i == GPIO_INT_STATUS) begin
                status_q <= (status_q & ~wdata_i[NGPIO-1:0]) | edge_set;
            end else begin
                status_q <= status_q | edge_set;
            end
            gpio_evt_o <= |edge_set;
        end
    end

    // Input synchronizer and edge register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    always_comb begin
        case (offset_i)
            GPIO_DIR:        rdata_o = apb_data_t'(dir_q);
            GPIO_OUT:        rdata_o = apb_data_t'(out_q);
            GPIO_IN:         rdata_o = apb_data_t'(sync2_q);
            GPIO_INT_EN:     rdata_o = apb_data_t'(int_en_q);
            GPIO_INT_STATUS: rdata_o = apb_data_t'(status_q);
            default:         rdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

    status_needs_enable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (status_q & ~$past(status_q) & ~$past(int_en_q)) == '0);

endmodule

// ==== logic/apb_timer.sv ====
/*
 * Compare timer with a 32-bit up counter.
 * Source 0 ticks every clock, source 1 on each slow-clock rising edge.
 * At the compare value the counter wraps to 0 and irq_o pulses, so
 * pulses are TIM_CMP+1 ticks apart. Writing TIM_CFG clears the counter.
 */
`timescale 1ns/10ps

module apb_timer import periph_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      sel_i,
    input  logic      enable_i,
    input  logic      write_i,
    input  reg_off_t  offset_i,
    input  apb_data_t wdata_i,
    output apb_data_t rdata_o,
    input  logic      slow_tick_i,
    output logic      irq_o
);

    logic [1:0] cfg_q;
    apb_data_t  cmp_q;
    apb_data_t  cnt_q;
    logic       wr;
    logic       cfg_wr;
    logic       tick;
    logic       match;

    assign wr     = sel_i & enable_i & write_i;
    assign cfg_wr = wr & (offset_i == TIM_CFG);

    // Count source select
    assign tick  = cfg_q[TIM_CFG_EN] & (cfg_q[TIM_CFG_SRC] ? slow_tick_i : 1'b1);
    assign match = (cnt_q == cmp_q);

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
            cmp_q <= '0;
        end else begin
            if (cfg_wr) cfg_q <= wdata_i[1:0];
            if (wr && offset_i == TIM_CMP) cmp_q <= wdata_i;
        end
    end

    ////////////////////
    // Counter
    ////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            irq_o <= 1'b0;
        end else begin
            irq_o <= tick & match & ~cfg_wr;
            if (cfg_wr) begin
                cnt_q <= '0;
            end else if (tick) begin
                cnt_q <= match ? '0 : cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (offset_i)
            TIM_CFG: rdata_o = apb_data_t'(cfg_q);
            TIM_CNT: rdata_o = cnt_q;
            TIM_CMP: rdata_o = cmp_q;
            default: rdata_o = '0;
        endcase
    end

    // Back-to-back interrupts only when every tick wraps
    irq_spacing_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_o && $past(irq_o) |-> ($past(cmp_q) == '0));

endmodule

// ==== logic/soc_peripherals.sv ====
/*
 * APB peripheral subsystem: decoder, GPIO, compare timer and
 * slow-clock edge detection, with events mapped onto the FC vector.
 * All logic runs on clk_i; slow_clk_i is treated as asynchronous.
 */
`timescale 1ns/10ps

module soc_peripherals import periph_pkg::*, event_pkg::*; #(
    parameter int unsigned NGPIO = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  apb_addr_t        paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  apb_data_t        pwdata_i,
    output apb_data_t        prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  logic             slow_clk_i,
    input  logic [NGPIO-1:0] gpio_i,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,
    output fc_event_t        fc_events_o
);

    logic      gpio_sel, tim_sel;
    logic      per_enable, per_write;
    reg_off_t  per_offset;
    apb_data_t per_wdata;
    apb_data_t gpio_rdata, tim_rdata;
    logic      gpio_evt, tim_irq;
    logic      ref_rise, ref_fall;

    ////////////////////
    // APB decode
    ////////////////////
    apb_periph_decode i_decode (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .paddr_i      ( paddr_i    ),
        .psel_i       ( psel_i     ),
        .penable_i    ( penable_i  ),
        .pwrite_i     ( pwrite_i   ),
        .pwdata_i     ( pwdata_i   ),
        .prdata_o     ( prdata_o   ),
        .pready_o     ( pready_o   ),
        .pslverr_o    ( pslverr_o  ),
        .gpio_sel_o   ( gpio_sel   ),
        .tim_sel_o    ( tim_sel    ),
        .enable_o     ( per_enable ),
        .write_o      ( per_write  ),
        .offset_o     ( per_offset ),
        .wdata_o      ( per_wdata  ),
        .gpio_rdata_i ( gpio_rdata ),
        .tim_rdata_i  ( tim_rdata  )
    );

    ////////////////////
    // Peripherals
    ////////////////////
    apb_gpio #(.NGPIO(NGPIO)) i_gpio (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .sel_i      ( gpio_sel   ),
        .enable_i   ( per_enable ),
        .write_i    ( per_write  ),
        .offset_i   ( per_offset ),
        .wdata_i    ( per_wdata  ),
        .rdata_o    ( gpio_rdata ),
        .gpio_i     ( gpio_i     ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_evt_o ( gpio_evt   )
    );

    apb_timer i_timer (
        .clk_i       ( clk_i      ),
        .rst_n_i     ( rst_n_i    ),
        .sel_i       ( tim_sel    ),
        .enable_i    ( per_enable ),
        .write_i     ( per_write  ),
        .offset_i    ( per_offset ),
        .wdata_i     ( per_wdata  ),
        .rdata_o     ( tim_rdata  ),
        .slow_tick_i ( ref_rise   ),
        .irq_o       ( tim_irq    )
    );

    slow_clk_edge i_ref_edge (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .slow_clk_i ( slow_clk_i ),
        .rise_o     ( ref_rise   ),
        .fall_o     ( ref_fall   )
    );

    // Unused event positions stay low
    always_comb begin
        fc_events_o              = '0;
        fc_events_o[EVT_TIMER]   = tim_irq;
        fc_events_o[EVT_REF_CLK] = ref_rise | ref_fall;
        fc_events_o[EVT_GPIO]    = gpio_evt;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
/*
 * Clock and reset source for the testbench.
 * Reset is released 1 ns after the RST_CYCLES-th rising edge.
 */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// ==== dv/tb_soc_peripherals.sv ====
/*
 * Testbench for the APB peripheral subsystem.
 * Random APB traffic and gpio_i patterns from a fixed seed, checked
 * against a register and event model. slow_clk toggles every 5 cycles.
 * Events are sampled on the falling clock edge. Stops at the first error.
 */
`timescale 1ns/10ps

module tb_soc_peripherals import periph_pkg::*, event_pkg::*; ();

    localparam int NGPIO   = 32;
    localparam int CLK_NS  = 8;
    localparam int N_REG   = 40;
    localparam int N_ERR   = 30;
    localparam int N_GPIO  = 20;
    localparam int N_TIM   = 3;
    localparam int N_PULSE = 5;
    localparam int SETTLE  = 5;
    // Watchdog budget of 2 cycles per transfer plus timer waits and a margin
    localparam int N_XFER   = N_REG * 2 + N_ERR * 2 + 5 + N_GPIO * 5 + N_TIM * 2 * 3;
    localparam int TIM_CYC  = N_TIM * ((N_PULSE + 3) * (16 + 40) + 60);
    localparam int WDOG_CYC = N_XFER * 2 + TIM_CYC + N_GPIO * SETTLE + 200;
    localparam fc_event_t USED_EVT = fc_event_t'((1 << EVT_TIMER) | (1 << EVT_REF_CLK) |
                                                 (1 << EVT_GPIO));

    logic             clk, rst_n;
    apb_addr_t        paddr;
    logic             psel, penable, pwrite, pready, pslverr, slow_clk;
    apb_data_t        pwdata, prdata;
    logic [NGPIO-1:0] gpio_in, gpio_out, gpio_dir;
    fc_event_t        fc_events;

    // Model state and event records
    apb_data_t        dir_m, out_m, int_en_m, cmp_m, status_m;
    logic [NGPIO-1:0] gpio_cur;
    int               gpio_evt_exp;
    int               cyc = 0;
    int               ref_cnt = 0;
    int               gpio_evt_cnt = 0;
    int               tim_pulse[$];
    int               toggles[$];
    integer           seed = 32'h6b47;

    tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(3)) i_clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    soc_peripherals #(.NGPIO(NGPIO)) i_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .paddr_i     ( paddr     ),
        .psel_i      ( psel      ),
        .penable_i   ( penable   ),
        .pwrite_i    ( pwrite    ),
        .pwdata_i    ( pwdata    ),
        .prdata_o    ( prdata    ),
        .pready_o    ( pready    ),
        .pslverr_o   ( pslverr   ),
        .slow_clk_i  ( slow_clk  ),
        .gpio_i      ( gpio_in   ),
        .gpio_out_o  ( gpio_out  ),
        .gpio_dir_o  ( gpio_dir  ),
        .fc_events_o ( fc_events )
    );

    ////////////////////
    // Checks
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_events(input string name, input fc_event_t got, input fc_event_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_gpio(input string name, input logic [NGPIO-1:0] got,
                              input logic [NGPIO-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    ////////////////////
    // Bus and timing helpers
    ////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Setup and access cycle followed by an idle bus
    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        step();
        penable = 1'b1;
        #1;
        if (pready !== 1'b1)
            abort_run($sformatf("pready_o was low in an access cycle at %0t", $time));
        rdata = prdata;
        err   = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rd;
        logic      err;
        apb_xfer(addr, 1'b1, wdata, rd, err);
        check_bit("pslverr_o", err, 1'b0);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rd);
        logic err;
        apb_xfer(addr, 1'b0, '0, rd, err);
        check_bit("pslverr_o", err, 1'b0);
    endtask

    function automatic int toggles_upto(input int c);
        int k;
        k = 0;
        foreach (toggles[j])
            if (toggles[j] <= c) k++;
        return k;
    endfunction

    task automatic wait_timer_pulses(input int n, input int max_cycles);
        int waited;
        waited = 0;
        while (tim_pulse.size() < n) begin
            if (waited >= max_cycles)
                abort_run($sformatf("timer event missing after %0d cycles", waited));
            step();
            waited++;
        end
    endtask

    // One timer run; tick_cycles is the clock count per tick of the source
    task automatic run_timer(input logic src, input int tick_cycles);
        apb_data_t cmp;
        int        period, s_cyc, s_ref;
        cmp    = $random(seed) & (src ? 3 : 15);
        period = (int'(cmp) + 1) * tick_cycles;
        apb_write({TIMER_BASE, TIM_CMP}, cmp);
        cmp_m = cmp;
        apb_write({TIMER_BASE, TIM_CFG}, apb_data_t'({src, 1'b1}));
        tim_pulse.delete();
        #4;
        s_cyc = cyc;
        s_ref = ref_cnt;
        step();
        wait_timer_pulses(N_PULSE, (N_PULSE + 3) * period + 20);
        for (int i = 1; i < N_PULSE; i++)
            check_count("EVT_TIMER spacing", tim_pulse[i] - tim_pulse[i-1], period);
        #4;
        check_count("EVT_REF_CLK pulses", ref_cnt - s_ref,
                    toggles_upto(cyc - 3) - toggles_upto(s_cyc - 3));
        step();
        apb_write({TIMER_BASE, TIM_CFG}, '0);
    endtask

    ////////////////////
    // Monitors
    ////////////////////
    always @(posedge clk) cyc <= cyc + 1;

    always @(negedge clk) begin
        if (rst_n) begin
            check_events("fc_events_o unused bits", fc_events & ~USED_EVT, '0);
            if (fc_events[EVT_TIMER]) tim_pulse.push_back(cyc);
            if (fc_events[EVT_REF_CLK]) ref_cnt++;
            if (fc_events[EVT_GPIO]) gpio_evt_cnt++;
        end
    end

    // Slow reference clock toggling every 5 cycles
    initial begin
        slow_clk = 1'b0;
        @(posedge rst_n);
        forever begin
            repeat (5) step();
            slow_clk = ~slow_clk;
            toggles.push_back(cyc);
        end
    end

    initial begin
        #(WDOG_CYC * CLK_NS);
        abort_run($sformatf("watchdog expired after %0d cycles", WDOG_CYC));
    end

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        apb_data_t        data, rd, clr;
        apb_addr_t        addr;
        logic [WIN_W-1:0] win;
        logic [NGPIO-1:0] rising;
        logic             wr, err;
        int               sel;

        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        gpio_in = '0;
        {dir_m, out_m, int_en_m, cmp_m, status_m} = '0;
        gpio_cur     = '0;
        gpio_evt_exp = 0;
        @(posedge rst_n);
        step();
        check_gpio("gpio_out_o", gpio_out, '0);
        check_gpio("gpio_dir_o", gpio_dir, '0);
        check_bit("pslverr_o", pslverr, 1'b0);
        check_events("fc_events_o", fc_events, '0);

        // Register write and readback
        for (int n = 0; n < N_REG; n++) begin
            sel  = $random(seed) & 3;
            data = $random(seed);
            case (sel)
                0:       addr = {GPIO_BASE, GPIO_DIR};
                1:       addr = {GPIO_BASE, GPIO_OUT};
                2:       addr = {GPIO_BASE, GPIO_INT_EN};
                default: addr = {TIMER_BASE, TIM_CMP};
            endcase
            apb_write(addr, data);
            case (sel)
                0:       dir_m = data;
                1:       out_m = data;
                2:       int_en_m = data;
                default: cmp_m = data;
            endcase
            apb_read(addr, rd);
            check_data($sformatf("prdata_o @%h", addr), rd, data);
            check_gpio("gpio_dir_o", gpio_dir, dir_m[NGPIO-1:0]);
            check_gpio("gpio_out_o", gpio_out, out_m[NGPIO-1:0]);
        end

        // Unmapped windows answer with an error and mapped ones without
        for (int n = 0; n < N_ERR; n++) begin
            win = WIN_W'($random(seed));
            if (win < 2) win = win + 2;
            wr   = ($random(seed) & 1) != 0;
            data = $random(seed);
            apb_xfer({win, reg_off_t'($random(seed))}, wr, data, rd, err);
            check_bit("pslverr_o", err, 1'b1);
            if (!wr) check_data("prdata_o", rd, '0);
            win = WIN_W'($random(seed) & 1);
            apb_read({win, reg_off_t'($random(seed) & 'h1C)}, rd);
        end
        apb_read({GPIO_BASE, GPIO_DIR}, rd);
        check_data("GPIO_DIR", rd, dir_m);
        apb_read({GPIO_BASE, GPIO_OUT}, rd);
        check_data("GPIO_OUT", rd, out_m);
        apb_read({GPIO_BASE, GPIO_INT_EN}, rd);
        check_data("GPIO_INT_EN", rd, int_en_m);
        apb_read({TIMER_BASE, TIM_CMP}, rd);
        check_data("TIM_CMP", rd, cmp_m);

        // GPIO inputs, sticky status and write-1-to-clear
        int_en_m = $random(seed);
        apb_write({GPIO_BASE, GPIO_INT_EN}, int_en_m);
        for (int n = 0; n < N_GPIO; n++) begin
            data   = $random(seed);
            rising = data[NGPIO-1:0] & ~gpio_cur & int_en_m[NGPIO-1:0];
            if (rising != '0) gpio_evt_exp++;
            status_m[NGPIO-1:0] = status_m[NGPIO-1:0] | rising;
            gpio_in  = data[NGPIO-1:0];
            gpio_cur = data[NGPIO-1:0];
            repeat (SETTLE) step();
            apb_read({GPIO_BASE, GPIO_IN}, rd);
            check_data("GPIO_IN", rd, apb_data_t'(gpio_cur));
            apb_read({GPIO_BASE, GPIO_INT_STATUS}, rd);
            check_data("GPIO_INT_STATUS", rd, status_m);
            check_count("EVT_GPIO pulses", gpio_evt_cnt, gpio_evt_exp);
            clr = $random(seed);
            apb_write({GPIO_BASE, GPIO_INT_STATUS}, clr);
            status_m = status_m & ~clr;
            apb_read({GPIO_BASE, GPIO_INT_STATUS}, rd);
            check_data("GPIO_INT_STATUS after clear", rd, status_m);
        end

        // Timer on the system clock and then on slow-clock rising edges
        for (int n = 0; n < N_TIM; n++)
            run_timer(1'b0, 1);
        for (int n = 0; n < N_TIM; n++)
            run_timer(1'b1, 10);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/periph_pkg.sv
logic/event_pkg.sv
logic/slow_clk_edge.sv
logic/apb_periph_decode.sv
logic/apb_gpio.sv
logic/apb_timer.sv
logic/soc_peripherals.sv
dv/tb_clk_gen.sv
dv/tb_soc_peripherals.sv

// ==== Makefile ====
# Verilator build and run for the APB peripheral subsystem testbench

TOP = tb_soc_peripherals
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

# Pass or fail is decided by the pass line in the log
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
